// File: bench/mem_back_end_tb.sv
`timescale 1ns/1ps

module mem_back_end_tb;

    import core_pkg::*;

    // About 170 instructions of two cycles each, plus two resets.
    localparam int INSTR_COUNT = 200;
    localparam int MARGIN = 10;
    localparam int TIMEOUT_CYCLES = INSTR_COUNT * MARGIN;

    logic                  clk;
    logic                  rst_n;
    logic [PC_BIT-1:0]     ex_pc_4;
    logic [31:0]           ex_rt_data;
    logic [4:0]            ex_reg_w;
    logic                  ex_reg_w_en;
    logic [31:0]           ex_alu_res;
    logic [DM_OP_BIT-1:0]  ex_dm_op;
    logic                  ex_dm_w_en;
    logic [WB_SEL_BIT-1:0] ex_wb_sel;
    logic                  ex_syscall;
    logic                  hold;
    logic                  flush;
    logic                  wb_en;
    logic [4:0]            wb_reg;
    logic [31:0]           wb_data;
    logic                  halted;

    // Byte-wide reference copy of the data memory.
    logic [7:0] ref_mem [DM_WORDS*4];

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    mem_back_end mem_back_end_i (
        .clk(clk), .rst_n(rst_n), .ex_pc_4(ex_pc_4), .ex_rt_data(ex_rt_data),
        .ex_reg_w(ex_reg_w), .ex_reg_w_en(ex_reg_w_en), .ex_alu_res(ex_alu_res),
        .ex_dm_op(ex_dm_op), .ex_dm_w_en(ex_dm_w_en), .ex_wb_sel(ex_wb_sel),
        .ex_syscall(ex_syscall), .hold(hold), .flush(flush), .wb_en(wb_en),
        .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic drive_nop();
        ex_pc_4     = '0;
        ex_rt_data  = '0;
        ex_reg_w    = '0;
        ex_reg_w_en = 1'b0;
        ex_alu_res  = '0;
        ex_dm_op    = dm_none;
        ex_dm_w_en  = 1'b0;
        ex_wb_sel   = wb_alu;
        ex_syscall  = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
    endtask

    task automatic issue_instr(input logic [31:0] alu, input logic [31:0] rt,
                               input logic [DM_OP_BIT-1:0] op, input logic w_en,
                               input logic [WB_SEL_BIT-1:0] sel, input logic [4:0] rg,
                               input logic rg_en, input logic [31:0] pc, input logic sc);
        ex_alu_res  = alu;
        ex_rt_data  = rt;
        ex_dm_op    = op;
        ex_dm_w_en  = w_en;
        ex_wb_sel   = sel;
        ex_reg_w    = rg;
        ex_reg_w_en = rg_en;
        ex_pc_4     = pc;
        ex_syscall  = sc;
    endtask

    // Capture at the first edge, write-back visible after the second.
    task automatic expect_wb(input logic en, input logic [4:0] rg, input logic [31:0] data);
        step();
        drive_nop();
        step();
        check_value("wb_en", {31'd0, en}, {31'd0, wb_en});
        if (en) begin
            check_value("wb_reg", {27'd0, rg}, {27'd0, wb_reg});
            check_value("wb_data", data, wb_data);
        end
    endtask

    task automatic model_store(input logic [9:0] addr, input logic [31:0] data,
                               input logic [DM_OP_BIT-1:0] op);
        logic [9:0] a;
        if (op == dm_word) begin
            a = {addr[9:2], 2'b00};
            ref_mem[a]         = data[7:0];
            ref_mem[a + 10'd1] = data[15:8];
            ref_mem[a + 10'd2] = data[23:16];
            ref_mem[a + 10'd3] = data[31:24];
        end else if (op == dm_half || op == dm_half_u) begin
            a = {addr[9:1], 1'b0};
            ref_mem[a]         = data[7:0];
            ref_mem[a + 10'd1] = data[15:8];
        end else if (op == dm_byte || op == dm_byte_u) begin
            ref_mem[addr] = data[7:0];
        end
    endtask

    function automatic logic [31:0] model_load(input logic [9:0] addr,
                                               input logic [DM_OP_BIT-1:0] op);
        logic [9:0]  wa;
        logic [9:0]  ha;
        logic [15:0] h;
        logic [7:0]  b;
        wa = {addr[9:2], 2'b00};
        ha = {addr[9:1], 1'b0};
        h  = {ref_mem[ha + 10'd1], ref_mem[ha]};
        b  = ref_mem[addr];
        case (op)
            dm_half:   model_load = {{16{h[15]}}, h};
            dm_half_u: model_load = {16'h0000, h};
            dm_byte:   model_load = {{24{b[7]}}, b};
            dm_byte_u: model_load = {24'h000000, b};
            default:   model_load = {ref_mem[wa + 10'd3], ref_mem[wa + 10'd2],
                                     ref_mem[wa + 10'd1], ref_mem[wa]};
        endcase
    endfunction

    task automatic store_data(input logic [9:0] addr, input logic [31:0] data,
                              input logic [DM_OP_BIT-1:0] op);
        issue_instr({22'd0, addr}, data, op, 1'b1, wb_alu, 5'd0, 1'b0, 32'd0, 1'b0);
        expect_wb(1'b0, 5'd0, 32'd0);
        model_store(addr, data, op);
    endtask

    task automatic load_check(input logic [9:0] addr, input logic [DM_OP_BIT-1:0] op);
        logic [31:0] r;
        r = $urandom;
        issue_instr({22'd0, addr}, $urandom, op, 1'b0, wb_mem, r[4:0], 1'b1, 32'd0, 1'b0);
        expect_wb(1'b1, r[4:0], model_load(addr, op));
    endtask

    task automatic alu_and_link();
        logic [31:0] val;
        logic [31:0] pc;
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            val = $urandom;
            pc  = $urandom;
            r   = $urandom;
            issue_instr(val, 32'd0, dm_none, 1'b0, wb_alu, r[4:0], 1'b1, pc, 1'b0);
            expect_wb(1'b1, r[4:0], val);
            issue_instr(val, 32'd0, dm_none, 1'b0, wb_pc4, r[4:0], 1'b1, pc, 1'b0);
            expect_wb(1'b1, r[4:0], pc);
            issue_instr(val, 32'd0, dm_none, 1'b0, wb_alu, r[4:0], 1'b0, pc, 1'b0);
            expect_wb(1'b0, r[4:0], val);
        end
    endtask

    task automatic store_load_widths();
        logic [31:0] r;
        logic [9:0]  base;
        for (int n = 0; n < 8; n++) begin
            r    = $urandom;
            base = {r[7:0], 2'b00};
            store_data(base, $urandom, dm_word);
            store_data(base + {8'd0, r[8], 1'b0}, $urandom, dm_half);
            store_data(base + {8'd0, r[10:9]}, $urandom, dm_byte);
            load_check(base, dm_word);
            for (int k = 0; k < 4; k += 2) begin
                load_check(base + 10'(k), dm_half);
                load_check(base + 10'(k), dm_half_u);
            end
            for (int k = 0; k < 4; k++) begin
                load_check(base + 10'(k), dm_byte);
                load_check(base + 10'(k), dm_byte_u);
            end
        end
    endtask

    task automatic hold_store();
        logic [9:0] base;
        base = 10'h100;
        store_data(base, 32'h11223344, dm_word);
        issue_instr({22'd0, base + 10'd1}, 32'h000000a5, dm_byte, 1'b1, wb_alu,
                    5'd9, 1'b1, 32'd0, 1'b0);
        step();
        // Store now sits in MEM and stays there.
        drive_nop();
        hold = 1'b1;
        repeat (3) begin
            step();
            check_value("wb_en", 32'd0, {31'd0, wb_en});
            check_value("mem_word", model_load(base, dm_word),
                        mem_back_end_i.data_mem_i.mem[base[9:2]].w);
        end
        hold = 1'b0;
        step();
        check_value("wb_en", 32'd1, {31'd0, wb_en});
        check_value("wb_reg", 32'd9, {27'd0, wb_reg});
        check_value("wb_data", {22'd0, base + 10'd1}, wb_data);
        model_store(base + 10'd1, 32'h000000a5, dm_byte);
        load_check(base + 10'd2, dm_byte_u);
        load_check(base, dm_word);
    endtask

    task automatic flush_squash();
        issue_instr(32'h00000100, 32'hdeadbeef, dm_word, 1'b1, wb_alu, 5'd0, 1'b0,
                    32'd0, 1'b0);
        flush = 1'b1;
        expect_wb(1'b0, 5'd0, 32'd0);
        load_check(10'h100, dm_word);
        issue_instr(32'h12345678, 32'd0, dm_none, 1'b0, wb_alu, 5'd3, 1'b1, 32'd0, 1'b0);
        flush = 1'b1;
        expect_wb(1'b0, 5'd3, 32'd0);
    endtask

    task automatic syscall_halt();
        int waited;
        issue_instr(32'd0, 32'd0, dm_none, 1'b0, wb_alu, 5'd0, 1'b0, 32'd0, 1'b1);
        expect_wb(1'b0, 5'd0, 32'd0);
        waited = 0;
        while (!halted && waited < 4) begin
            step();
            waited++;
        end
        if (!halted) begin
            errors++;
            $display("halted did not rise after the syscall reached write-back");
        end
        issue_instr(32'hcafe0000, 32'd0, dm_none, 1'b0, wb_alu, 5'd4, 1'b1, 32'd0, 1'b0);
        expect_wb(1'b0, 5'd4, 32'd0);
        issue_instr(32'h00000100, 32'hdeadbeef, dm_word, 1'b1, wb_alu, 5'd0, 1'b0,
                    32'd0, 1'b0);
        expect_wb(1'b0, 5'd0, 32'd0);
        repeat (4) begin
            step();
            check_value("wb_en", 32'd0, {31'd0, wb_en});
        end
        check_value("mem_word", model_load(10'h100, dm_word),
                    mem_back_end_i.data_mem_i.mem[64].w);
        apply_reset();
        check_value("halted", 32'd0, {31'd0, halted});
        issue_instr(32'h00c0ffee, 32'd0, dm_none, 1'b0, wb_alu, 5'd5, 1'b1, 32'd0, 1'b0);
        expect_wb(1'b1, 5'd5, 32'h00c0ffee);
    endtask

    initial begin
        void'($urandom(7003));
        rst_n = 1'b0;
        hold  = 1'b0;
        drive_nop();
        for (int i = 0; i < DM_WORDS * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        apply_reset();
        alu_and_link();
        store_load_widths();
        hold_store();
        flush_squash();
        syscall_halt();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    // Datapath widths.
    localparam int PC_BIT = 32;
    localparam int DM_ADDR_BIT = 10;
    localparam int DM_WORDS = 256;
    localparam int DM_OP_BIT = 3;
    localparam int WB_SEL_BIT = 2;

    // Memory operation codes. Zero means no access.
    localparam logic [DM_OP_BIT-1:0] dm_none   = 3'd0;
    localparam logic [DM_OP_BIT-1:0] dm_word   = 3'd1;
    localparam logic [DM_OP_BIT-1:0] dm_half   = 3'd2;
    localparam logic [DM_OP_BIT-1:0] dm_half_u = 3'd3;
    localparam logic [DM_OP_BIT-1:0] dm_byte   = 3'd4;
    localparam logic [DM_OP_BIT-1:0] dm_byte_u = 3'd5;

    // Write-back source select.
    localparam logic [WB_SEL_BIT-1:0] wb_alu = 2'd0;
    localparam logic [WB_SEL_BIT-1:0] wb_mem = 2'd1;
    localparam logic [WB_SEL_BIT-1:0] wb_pc4 = 2'd2;

    // One memory word, seen whole or as little-endian byte lanes.
    typedef union packed {
        logic [31:0]     w;
        logic [3:0][7:0] b;
    } mem_word_u;

endpackage

// File: logic/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [core_pkg::DM_ADDR_BIT-1:0]  addr,
    input  logic                              w_en,
    input  logic [core_pkg::DM_OP_BIT-1:0]    dm_op,
    input  logic [31:0]                       w_data,
    output core_pkg::mem_word_u               r_word
);

    import core_pkg::*;

    mem_word_u mem [DM_WORDS];

    // One flag per word, set by the first store after reset.
    logic [DM_WORDS-1:0] written;

    logic [DM_ADDR_BIT-3:0] idx;
    logic [1:0]             lane;
    mem_word_u              merged;
    logic                   store;

    assign idx  = addr[DM_ADDR_BIT-1:2];
    assign lane = addr[1:0];

    // Words not yet stored read as zero.
    assign r_word = written[idx] ? mem[idx] : '0;

    // Merge the store data into the lanes picked by size and offset.
    always_comb begin
        merged = r_word;
        store  = w_en;
        case (dm_op)
            dm_word: begin
                merged.w = w_data;
            end
            dm_half, dm_half_u: begin
                merged.b[{lane[1], 1'b0}] = w_data[7:0];
                merged.b[{lane[1], 1'b1}] = w_data[15:8];
            end
            dm_byte, dm_byte_u: begin
                merged.b[lane] = w_data[7:0];
            end
            default: begin
                store = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[idx] <= merged;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else if (store) begin
            written[idx] <= 1'b1;
        end
    end

endmodule

// File: logic/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 en,
    input  logic                                 clear,
    input  logic [core_pkg::PC_BIT-1:0]          pc_4_in,
    input  logic [31:0]                          rt_data_in,
    input  logic [4:0]                           reg_w_in,
    input  logic                                 reg_w_en_in,
    input  logic [31:0]                          alu_res_in,
    input  logic [core_pkg::DM_OP_BIT-1:0]       dm_op_in,
    input  logic                                 dm_w_en_in,
    input  logic [core_pkg::WB_SEL_BIT-1:0]      wb_sel_in,
    input  logic                                 syscall_in,
    output logic [core_pkg::PC_BIT-1:0]          pc_4,
    output logic [31:0]                          rt_data,
    output logic [4:0]                           reg_w,
    output logic                                 reg_w_en,
    output logic [31:0]                          alu_res,
    output logic [core_pkg::DM_OP_BIT-1:0]       dm_op,
    output logic                                 dm_w_en,
    output logic [core_pkg::WB_SEL_BIT-1:0]      wb_sel,
    output logic                                 syscall
);

    // All zero fields form a no-op bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_4     <= '0;
            rt_data  <= '0;
            reg_w    <= '0;
            reg_w_en <= 1'b0;
            alu_res  <= '0;
            dm_op    <= '0;
            dm_w_en  <= 1'b0;
            wb_sel   <= '0;
            syscall  <= 1'b0;
        end else if (clear) begin
            pc_4     <= '0;
            rt_data  <= '0;
            reg_w    <= '0;
            reg_w_en <= 1'b0;
            alu_res  <= '0;
            dm_op    <= '0;
            dm_w_en  <= 1'b0;
            wb_sel   <= '0;
            syscall  <= 1'b0;
        end else if (en) begin
            pc_4     <= pc_4_in;
            rt_data  <= rt_data_in;
            reg_w    <= reg_w_in;
            reg_w_en <= reg_w_en_in;
            alu_res  <= alu_res_in;
            dm_op    <= dm_op_in;
            dm_w_en  <= dm_w_en_in;
            wb_sel   <= wb_sel_in;
            syscall  <= syscall_in;
        end
    end

endmodule

// File: logic/load_format.sv
`timescale 1ns/1ps

module load_format (
    input  core_pkg::mem_word_u             word,
    input  logic [1:0]                      addr_low,
    input  logic [core_pkg::DM_OP_BIT-1:0]  dm_op,
    output logic [31:0]                     data
);

    import core_pkg::*;

    logic [15:0] half_sel;
    logic [7:0]  lane_byte;

    // Halves sit on lanes 0-1 or 2-3.
    assign half_sel  = addr_low[1] ? {word.b[3], word.b[2]} : {word.b[1], word.b[0]};
    assign lane_byte = word.b[addr_low];

    always_comb begin
        case (dm_op)
            dm_half:   data = {{16{half_sel[15]}}, half_sel};
            dm_half_u: data = {16'h0000, half_sel};
            dm_byte:   data = {{24{lane_byte[7]}}, lane_byte};
            dm_byte_u: data = {24'h000000, lane_byte};
            default:   data = word.w;  // word load
        endcase
    end

endmodule

// File: logic/mem_back_end.sv
`timescale 1ns/1ps

module mem_back_end (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [core_pkg::PC_BIT-1:0]        ex_pc_4,
    input  logic [31:0]                        ex_rt_data,
    input  logic [4:0]                         ex_reg_w,
    input  logic                               ex_reg_w_en,
    input  logic [31:0]                        ex_alu_res,
    input  logic [core_pkg::DM_OP_BIT-1:0]     ex_dm_op,
    input  logic                               ex_dm_w_en,
    input  logic [core_pkg::WB_SEL_BIT-1:0]    ex_wb_sel,
    input  logic                               ex_syscall,
    input  logic                               hold,
    input  logic                               flush,
    output logic                               wb_en,
    output logic [4:0]                         wb_reg,
    output logic [31:0]                        wb_data,
    output logic                               halted
);

    import core_pkg::*;

    logic                  exm_en, exm_clear, mwb_en, mwb_clear;
    logic [PC_BIT-1:0]     mem_pc_4;
    logic [31:0]           mem_rt_data;
    logic [4:0]            mem_reg_w;
    logic                  mem_reg_w_en;
    logic [31:0]           mem_alu_res;
    logic [DM_OP_BIT-1:0]  mem_dm_op;
    logic                  mem_dm_w_en;
    logic [WB_SEL_BIT-1:0] mem_wb_sel;
    logic                  mem_syscall;
    logic                  wb_syscall;
    mem_word_u             r_word;
    logic [31:0]           load_data;

    pipe_control pipe_control_i (
        .clk(clk), .rst_n(rst_n), .hold(hold), .flush(flush), .syscall(wb_syscall),
        .exm_en(exm_en), .exm_clear(exm_clear), .mwb_en(mwb_en), .mwb_clear(mwb_clear),
        .halted(halted)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk(clk), .rst_n(rst_n), .en(exm_en), .clear(exm_clear),
        .pc_4_in(ex_pc_4), .rt_data_in(ex_rt_data), .reg_w_in(ex_reg_w),
        .reg_w_en_in(ex_reg_w_en), .alu_res_in(ex_alu_res), .dm_op_in(ex_dm_op),
        .dm_w_en_in(ex_dm_w_en), .wb_sel_in(ex_wb_sel), .syscall_in(ex_syscall),
        .pc_4(mem_pc_4), .rt_data(mem_rt_data), .reg_w(mem_reg_w),
        .reg_w_en(mem_reg_w_en), .alu_res(mem_alu_res), .dm_op(mem_dm_op),
        .dm_w_en(mem_dm_w_en), .wb_sel(mem_wb_sel), .syscall(mem_syscall)
    );

    // A held or halted store must not write.
    data_mem data_mem_i (
        .clk(clk), .rst_n(rst_n), .addr(mem_alu_res[DM_ADDR_BIT-1:0]),
        .w_en(mem_dm_w_en & mwb_en), .dm_op(mem_dm_op), .w_data(mem_rt_data),
        .r_word(r_word)
    );

    load_format load_format_i (
        .word(r_word), .addr_low(mem_alu_res[1:0]), .dm_op(mem_dm_op), .data(load_data)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk(clk), .rst_n(rst_n), .en(mwb_en), .clear(mwb_clear),
        .alu_res(mem_alu_res), .load_data(load_data), .pc_4(mem_pc_4),
        .wb_sel(mem_wb_sel), .reg_w(mem_reg_w), .reg_w_en(mem_reg_w_en),
        .syscall_in(mem_syscall), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
        .syscall(wb_syscall)
    );

endmodule

// File: logic/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic                               clear,
    input  logic [31:0]                        alu_res,
    input  logic [31:0]                        load_data,
    input  logic [core_pkg::PC_BIT-1:0]        pc_4,
    input  logic [core_pkg::WB_SEL_BIT-1:0]    wb_sel,
    input  logic [4:0]                         reg_w,
    input  logic                               reg_w_en,
    input  logic                               syscall_in,
    output logic                               wb_en,
    output logic [4:0]                         wb_reg,
    output logic [31:0]                        wb_data,
    output logic                               syscall
);

    import core_pkg::*;

    logic [31:0]           alu_res_q;
    logic [31:0]           load_data_q;
    logic [PC_BIT-1:0]     pc_4_q;
    logic [WB_SEL_BIT-1:0] wb_sel_q;

    // A bubble only needs the write enable and syscall flag low.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en   <= 1'b0;
            syscall <= 1'b0;
        end else if (clear) begin
            wb_en   <= 1'b0;
            syscall <= 1'b0;
        end else if (en) begin
            wb_en   <= reg_w_en;
            syscall <= syscall_in;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            alu_res_q   <= alu_res;
            load_data_q <= load_data;
            pc_4_q      <= pc_4;
            wb_sel_q    <= wb_sel;
            wb_reg      <= reg_w;
        end
    end

    always_comb begin
        case (wb_sel_q)
            wb_mem:  wb_data = load_data_q;
            wb_pc4:  wb_data = pc_4_q;
            default: wb_data = alu_res_q;
        endcase
    end

endmodule

// File: logic/pipe_control.sv
`timescale 1ns/1ps

module pipe_control (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic flush,
    input  logic syscall,
    output logic exm_en,
    output logic exm_clear,
    output logic mwb_en,
    output logic mwb_clear,
    output logic halted
);

    logic stop;

    // Sticky until reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (syscall) begin
            halted <= 1'b1;
        end
    end

    // A syscall in write-back already stops the instructions behind it.
    assign stop = halted | syscall;

    assign exm_en    = !(hold || stop);
    assign exm_clear = flush;
    assign mwb_en    = !(hold || stop);
    assign mwb_clear = hold | stop;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module mem_back_end_tb -f sim.f -o mem_back_end_sim \
    && ./obj_dir/mem_back_end_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1 || exit 0

// File: sim.f
logic/core_pkg.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/load_format.sv
logic/mem_wb_reg.sv
logic/pipe_control.sv
logic/mem_back_end.sv
bench/mem_back_end_tb.sv
